//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_decode_top
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q -F "** PASS **" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim.f
verilog/rv_pkg.sv
verilog/regfile.sv
verilog/id.sv
verilog/id_ex.sv
verilog/decode_top.sv
test/tb_decode_top.sv

//--- test/tb_decode_top.sv
`timescale 1ns/1ns

module tb_decode_top
  import rv_pkg::*;
();

  localparam int CLK_PERIOD      = 10;
  localparam int RESET_CYCLES    = 3;
  localparam int PRELOAD_CYCLES  = REG_NUM + 2;
  localparam int RANDOM_CYCLES   = 4000;
  localparam int DRAIN_CYCLES    = 3;
  localparam int WATCHDOG_MARGIN = 200;

  logic      clk;
  logic      rst_n_i;
  word_t     pc_i;
  inst_t     inst_i;
  logic      ex_wreg_i;
  word_t     ex_wreg_data_i;
  reg_addr_t ex_rd_i;
  logic      ex_memrd_i;
  logic      mem_wreg_i;
  word_t     mem_wreg_data_i;
  reg_addr_t mem_rd_i;
  logic      mem_memrd_i;
  logic      wb_we_i;
  reg_addr_t wb_rd_i;
  word_t     wb_data_i;
  logic      stall_o;
  logic      branch_taken_o;
  word_t     branch_target_o;
  word_t     iss_pc_o;
  aluop_t    iss_aluop_o;
  logic      iss_alusrc1_o;
  logic      iss_alusrc2_o;
  word_t     iss_imm_o;
  word_t     iss_rs1_data_o;
  word_t     iss_rs2_data_o;
  reg_addr_t iss_rd_o;
  logic      iss_wreg_o;
  logic      iss_memrd_o;
  logic      iss_memwr_o;
  logic      iss_mem2reg_o;
  func3_t    iss_func3_o;
  word_t     iss_link_addr_o;

  // cur_* is the decode of this cycle, exp_* what iss_* must show now
  word_t     cur_pc, exp_pc;
  aluop_t    cur_aluop, exp_aluop;
  logic      cur_alusrc1, exp_alusrc1;
  logic      cur_alusrc2, exp_alusrc2;
  word_t     cur_imm, exp_imm;
  word_t     cur_rs1d, exp_rs1d;
  word_t     cur_rs2d, exp_rs2d;
  reg_addr_t cur_rd, exp_rd;
  logic      cur_wreg, exp_wreg;
  logic      cur_memrd, exp_memrd;
  logic      cur_memwr, exp_memwr;
  logic      cur_mem2reg, exp_mem2reg;
  func3_t    cur_func3, exp_func3;
  word_t     cur_link, exp_link;
  logic      cur_stall;
  logic      cur_taken;
  word_t     cur_target;
  logic      exp_in_ds;
  logic      data_valid;   // iss data fields have no reset value
  word_t     gen_imm;      // immediate encoded into inst_i
  word_t     shadow [REG_NUM];
  word_t     rng_state;
  int        error_count;
  int        cycle_count;

  decode_top decode_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic word_t rand_word();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic aluop_t alu_onehot(input func3_t f3, input logic alt, input logic reg_form);
    int idx;
    case (f3)
      F3_ADD:  idx = (alt && reg_form) ? ALUOP_SUB : ALUOP_ADD;
      F3_SLL:  idx = ALUOP_SLL;
      F3_SLT:  idx = ALUOP_SLT;
      F3_SLTU: idx = ALUOP_SLTU;
      F3_XOR:  idx = ALUOP_XOR;
      F3_SR:   idx = alt ? ALUOP_SRA : ALUOP_SRL;
      F3_OR:   idx = ALUOP_OR;
      default: idx = ALUOP_AND;
    endcase
    return aluop_t'(1) << idx;
  endfunction

  // operand as the ex stage should see it
  function automatic word_t src_value(input logic used, input reg_addr_t r);
    if (!used || r == NOP_REG) return ZERO_WORD;
    if (ex_wreg_i && ex_rd_i == r) return ex_wreg_data_i;
    if (mem_wreg_i && mem_rd_i == r) return mem_wreg_data_i;
    if (wb_we_i && wb_rd_i == r) return wb_data_i;
    return shadow[r];
  endfunction

  function automatic logic load_use(input logic used, input reg_addr_t r);
    return used && ((ex_wreg_i && ex_memrd_i && ex_rd_i == r) ||
                    (mem_wreg_i && mem_memrd_i && mem_rd_i == r));
  endfunction

  function automatic logic branch_cond(input func3_t f3, input word_t a, input word_t b);
    case (f3)
      F3_BEQ:  return a == b;
      F3_BNE:  return a != b;
      F3_BLT:  return $signed(a) < $signed(b);
      F3_BGE:  return $signed(a) >= $signed(b);
      F3_BLTU: return a < b;
      F3_BGEU: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  task automatic report_mismatch(input string name, input word_t got, input word_t want);
    error_count++;
    $display("error %s: got %h, expected %h", name, got, want);
  endtask

  task automatic predict();
    opcode_t op;
    logic    use1;
    logic    use2;
    op          = inst_i[6:0];
    use1        = 1'b0;
    use2        = 1'b0;
    cur_pc      = pc_i;
    cur_func3   = inst_i[14:12];
    cur_aluop   = aluop_t'(1) << ALUOP_ADD;
    cur_alusrc1 = SRC1_FROM_REG;
    cur_alusrc2 = SRC2_FROM_REG;
    cur_imm     = ZERO_WORD;
    cur_rd      = NOP_REG;
    cur_wreg    = 1'b0;
    cur_memrd   = 1'b0;
    cur_memwr   = 1'b0;
    cur_mem2reg = 1'b0;
    cur_link    = ZERO_WORD;
    cur_taken   = 1'b0;
    cur_target  = ZERO_WORD;
    if (!exp_in_ds) begin // squashed slot keeps the defaults
      case (op)
        OP_LUI, OP_AUIPC: begin
          cur_rd      = inst_i[11:7];
          cur_wreg    = 1'b1;
          cur_alusrc2 = SRC2_FROM_IMM;
          cur_imm     = gen_imm;
          if (op == OP_AUIPC) cur_alusrc1 = SRC1_FROM_PC;
        end
        OP_JAL, OP_JALR: begin
          cur_aluop = aluop_t'(1) << ALUOP_LINK;
          cur_rd    = inst_i[11:7];
          cur_wreg  = 1'b1;
          cur_imm   = gen_imm;
          use1      = (op == OP_JALR);
        end
        OP_BRANCH: begin
          use1    = 1'b1;
          use2    = 1'b1;
          cur_imm = gen_imm;
        end
        OP_LOAD: begin
          cur_rd      = inst_i[11:7];
          cur_wreg    = 1'b1;
          cur_memrd   = 1'b1;
          cur_mem2reg = 1'b1;
          cur_alusrc2 = SRC2_FROM_IMM;
          cur_imm     = gen_imm;
          use1        = 1'b1;
        end
        OP_STORE: begin
          cur_memwr   = 1'b1;
          cur_alusrc2 = SRC2_FROM_IMM;
          cur_imm     = gen_imm;
          use1        = 1'b1;
          use2        = 1'b1;
        end
        OP_ARITHI, OP_ARITHR: begin
          cur_aluop = alu_onehot(cur_func3, inst_i[30], op == OP_ARITHR);
          cur_rd    = inst_i[11:7];
          cur_wreg  = 1'b1;
          use1      = 1'b1;
          use2      = (op == OP_ARITHR);
          if (op == OP_ARITHI) begin
            cur_alusrc2 = SRC2_FROM_IMM;
            cur_imm     = gen_imm;
          end
        end
        default: ;
      endcase
    end
    cur_rs1d  = src_value(use1, inst_i[19:15]);
    cur_rs2d  = src_value(use2, inst_i[24:20]);
    cur_stall = load_use(use1, inst_i[19:15]) || load_use(use2, inst_i[24:20]);
    if (!exp_in_ds && (op == OP_JAL || op == OP_JALR)) begin
      cur_taken  = 1'b1;
      cur_target = (op == OP_JAL) ? pc_i + gen_imm : cur_rs1d + gen_imm;
      cur_link   = pc_i + 32'd4;
    end else if (!exp_in_ds && op == OP_BRANCH) begin
      cur_taken  = branch_cond(cur_func3, cur_rs1d, cur_rs2d);
      cur_target = pc_i + gen_imm;
    end
  endtask

  // the rising edge has passed, move the model along
  task automatic advance_model();
    if (wb_we_i && wb_rd_i != NOP_REG) shadow[wb_rd_i] = wb_data_i;
    exp_pc      = cur_pc;
    exp_alusrc1 = cur_alusrc1;
    exp_alusrc2 = cur_alusrc2;
    exp_imm     = cur_imm;
    exp_rs1d    = cur_rs1d;
    exp_rs2d    = cur_rs2d;
    exp_func3   = cur_func3;
    exp_link    = cur_link;
    data_valid  = 1'b1;
    if (cur_stall) begin
      exp_aluop   = aluop_t'(1) << ALUOP_ADD;
      exp_rd      = NOP_REG;
      exp_wreg    = 1'b0;
      exp_memrd   = 1'b0;
      exp_memwr   = 1'b0;
      exp_mem2reg = 1'b0;
    end else begin
      exp_aluop   = cur_aluop;
      exp_rd      = cur_rd;
      exp_wreg    = cur_wreg;
      exp_memrd   = cur_memrd;
      exp_memwr   = cur_memwr;
      exp_mem2reg = cur_mem2reg;
      exp_in_ds   = cur_taken;
    end
  endtask

  task automatic finish_cycle();
    predict();
    @(negedge clk);
    advance_model();
    cycle_count++;
  endtask

  task automatic new_instruction();
    word_t       w;
    word_t       v;
    reg_addr_t   rd;
    reg_addr_t   r1;
    reg_addr_t   r2;
    func3_t      f3;
    int unsigned sel;
    w   = rand_word();
    v   = rand_word();
    sel = rand_word() % 10;
    rd  = {2'b00, w[2:0]}; // few registers, many hazards
    r1  = {2'b00, w[5:3]};
    r2  = {2'b00, w[8:6]};
    f3  = w[11:9];
    pc_i    = {w[31:12], v[11:2], 2'b00};
    gen_imm = ZERO_WORD;
    case (sel)
      0, 2: begin
        gen_imm = {{20{v[11]}}, v[11:0]};
        inst_i  = {gen_imm[11:0], r1, f3, rd, (sel == 0) ? OP_ARITHI : OP_LOAD};
      end
      1: inst_i = {1'b0, v[0], 5'b00000, r2, r1, f3, rd, OP_ARITHR};
      3: begin
        gen_imm = {{20{v[11]}}, v[11:0]};
        inst_i  = {gen_imm[11:5], r2, r1, f3, gen_imm[4:0], OP_STORE};
      end
      4, 5: begin
        gen_imm = {v[31:12], 12'h000};
        inst_i  = {gen_imm[31:12], rd, (sel == 4) ? OP_LUI : OP_AUIPC};
      end
      6, 7: begin
        gen_imm = {{19{v[12]}}, v[12:1], 1'b0};
        inst_i  = {gen_imm[12], gen_imm[10:5], r2, r1, f3, gen_imm[4:1], gen_imm[11], OP_BRANCH};
      end
      8: begin
        if (v[31]) begin
          gen_imm = {{11{v[20]}}, v[20:1], 1'b0};
          inst_i  = {gen_imm[20], gen_imm[10:1], gen_imm[11], gen_imm[19:12], rd, OP_JAL};
        end else begin
          gen_imm = {{20{v[11]}}, v[11:0]};
          inst_i  = {gen_imm[11:0], r1, 3'b000, rd, OP_JALR};
        end
      end
      default: inst_i = {v[31:7], v[0] ? OP_FENCE : OP_SYSTEM};
    endcase
  endtask

  task automatic random_inputs();
    word_t w;
    w               = rand_word();
    ex_wreg_i       = w[0];
    ex_memrd_i      = (w[2:1] == 2'b00);
    ex_rd_i         = {2'b00, w[5:3]};
    mem_wreg_i      = w[6];
    mem_memrd_i     = (w[8:7] == 2'b00);
    mem_rd_i        = {2'b00, w[11:9]};
    wb_we_i         = w[12];
    wb_rd_i         = {2'b00, w[15:13]};
    ex_wreg_data_i  = rand_word();
    mem_wreg_data_i = rand_word();
    wb_data_i       = rand_word();
    if (!cur_stall) new_instruction(); // stalled instruction is held
  endtask

  initial begin
    rng_state       = 32'd94308;
    error_count     = 0;
    cycle_count     = 0;
    rst_n_i         = 1'b0;
    pc_i            = ZERO_WORD;
    inst_i          = ZERO_WORD;
    ex_wreg_i       = 1'b0;
    ex_wreg_data_i  = ZERO_WORD;
    ex_rd_i         = NOP_REG;
    ex_memrd_i      = 1'b0;
    mem_wreg_i      = 1'b0;
    mem_wreg_data_i = ZERO_WORD;
    mem_rd_i        = NOP_REG;
    mem_memrd_i     = 1'b0;
    wb_we_i         = 1'b0;
    wb_rd_i         = NOP_REG;
    wb_data_i       = ZERO_WORD;
    gen_imm         = ZERO_WORD;
    exp_aluop       = aluop_t'(1) << ALUOP_ADD;
    exp_rd          = NOP_REG;
    exp_wreg        = 1'b0;
    exp_memrd       = 1'b0;
    exp_memwr       = 1'b0;
    exp_mem2reg     = 1'b0;
    exp_in_ds       = 1'b0;
    data_valid      = 1'b0;
    cur_stall       = 1'b0;
    cur_taken       = 1'b0;
    for (int r = 0; r < REG_NUM; r++) shadow[r] = ZERO_WORD;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;
    for (int r = 0; r < REG_NUM; r++) begin
      wb_we_i   = 1'b1;
      wb_rd_i   = reg_addr_t'(r);
      wb_data_i = rand_word();
      finish_cycle();
    end
    // write x0 while an addi reads it, then read it again
    wb_rd_i   = NOP_REG;
    wb_data_i = rand_word() | 32'h1;
    inst_i    = {12'h000, NOP_REG, F3_ADD, 5'd1, OP_ARITHI};
    finish_cycle();
    wb_we_i = 1'b0;
    finish_cycle();
    repeat (RANDOM_CYCLES) begin
      random_inputs();
      finish_cycle();
    end
    ex_wreg_i  = 1'b0;
    mem_wreg_i = 1'b0;
    wb_we_i    = 1'b0;
    repeat (DRAIN_CYCLES) finish_cycle();
    $display("%0d cycles run, %0d errors", cycle_count, error_count);
    if (error_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    #((RESET_CYCLES + PRELOAD_CYCLES + RANDOM_CYCLES + DRAIN_CYCLES) * CLK_PERIOD
      + WATCHDOG_MARGIN);
    $display("timeout, the stimulus did not finish in time");
    $display("** FAIL **");
    $finish;
  end

  stall_a: assert property (@(posedge clk) disable iff (!rst_n_i) stall_o == cur_stall)
    else report_mismatch("stall_o", 32'($sampled(stall_o)), 32'(cur_stall));
  taken_a: assert property (@(posedge clk) disable iff (!rst_n_i) branch_taken_o == cur_taken)
    else report_mismatch("branch_taken_o", 32'($sampled(branch_taken_o)), 32'(cur_taken));
  target_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    !cur_taken || branch_target_o == cur_target)
    else report_mismatch("branch_target_o", $sampled(branch_target_o), cur_target);
  wreg_a: assert property (@(posedge clk) disable iff (!rst_n_i) iss_wreg_o == exp_wreg)
    else report_mismatch("iss_wreg_o", 32'($sampled(iss_wreg_o)), 32'(exp_wreg));
  memrd_a: assert property (@(posedge clk) disable iff (!rst_n_i) iss_memrd_o == exp_memrd)
    else report_mismatch("iss_memrd_o", 32'($sampled(iss_memrd_o)), 32'(exp_memrd));
  memwr_a: assert property (@(posedge clk) disable iff (!rst_n_i) iss_memwr_o == exp_memwr)
    else report_mismatch("iss_memwr_o", 32'($sampled(iss_memwr_o)), 32'(exp_memwr));
  mem2reg_a: assert property (@(posedge clk) disable iff (!rst_n_i) iss_mem2reg_o == exp_mem2reg)
    else report_mismatch("iss_mem2reg_o", 32'($sampled(iss_mem2reg_o)), 32'(exp_mem2reg));
  aluop_a: assert property (@(posedge clk) disable iff (!rst_n_i) iss_aluop_o == exp_aluop)
    else report_mismatch("iss_aluop_o", 32'($sampled(iss_aluop_o)), 32'(exp_aluop));
  rd_a: assert property (@(posedge clk) disable iff (!rst_n_i) iss_rd_o == exp_rd)
    else report_mismatch("iss_rd_o", 32'($sampled(iss_rd_o)), 32'(exp_rd));
  pc_a: assert property (@(posedge clk) disable iff (!rst_n_i) !data_valid || iss_pc_o == exp_pc)
    else report_mismatch("iss_pc_o", $sampled(iss_pc_o), exp_pc);
  imm_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    !data_valid || iss_imm_o == exp_imm)
    else report_mismatch("iss_imm_o", $sampled(iss_imm_o), exp_imm);
  rs1_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    !data_valid || iss_rs1_data_o == exp_rs1d)
    else report_mismatch("iss_rs1_data_o", $sampled(iss_rs1_data_o), exp_rs1d);
  rs2_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    !data_valid || iss_rs2_data_o == exp_rs2d)
    else report_mismatch("iss_rs2_data_o", $sampled(iss_rs2_data_o), exp_rs2d);
  src1_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    !data_valid || iss_alusrc1_o == exp_alusrc1)
    else report_mismatch("iss_alusrc1_o", 32'($sampled(iss_alusrc1_o)), 32'(exp_alusrc1));
  src2_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    !data_valid || iss_alusrc2_o == exp_alusrc2)
    else report_mismatch("iss_alusrc2_o", 32'($sampled(iss_alusrc2_o)), 32'(exp_alusrc2));
  func3_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    !data_valid || iss_func3_o == exp_func3)
    else report_mismatch("iss_func3_o", 32'($sampled(iss_func3_o)), 32'(exp_func3));
  link_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    !data_valid || iss_link_addr_o == exp_link)
    else report_mismatch("iss_link_addr_o", $sampled(iss_link_addr_o), exp_link);

endmodule

//--- verilog/decode_top.sv
`timescale 1ns/1ns

module decode_top
  import rv_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n_i,
  input  word_t     pc_i,
  input  inst_t     inst_i,
  input  logic      ex_wreg_i,
  input  word_t     ex_wreg_data_i,
  input  reg_addr_t ex_rd_i,
  input  logic      ex_memrd_i,
  input  logic      mem_wreg_i,
  input  word_t     mem_wreg_data_i,
  input  reg_addr_t mem_rd_i,
  input  logic      mem_memrd_i,
  input  logic      wb_we_i,
  input  reg_addr_t wb_rd_i,
  input  word_t     wb_data_i,
  output logic      stall_o,
  output logic      branch_taken_o,
  output word_t     branch_target_o,
  output word_t     iss_pc_o,
  output aluop_t    iss_aluop_o,
  output logic      iss_alusrc1_o,
  output logic      iss_alusrc2_o,
  output word_t     iss_imm_o,
  output word_t     iss_rs1_data_o,
  output word_t     iss_rs2_data_o,
  output reg_addr_t iss_rd_o,
  output logic      iss_wreg_o,
  output logic      iss_memrd_o,
  output logic      iss_memwr_o,
  output logic      iss_mem2reg_o,
  output func3_t    iss_func3_o,
  output word_t     iss_link_addr_o
);

  logic      rs1_read;
  logic      rs2_read;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  word_t     rf_rdata1;
  word_t     rf_rdata2;
  aluop_t    aluop;
  logic      alusrc1;
  logic      alusrc2;
  word_t     imm;
  word_t     rs1_data;
  word_t     rs2_data;
  reg_addr_t rd;
  logic      wreg;
  logic      memrd;
  logic      memwr;
  logic      mem2reg;
  func3_t    func3;
  word_t     link_addr;
  logic      next_in_delayslot;
  logic      in_delayslot;

  regfile regfile_i (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .we_i     (wb_we_i),
    .waddr_i  (wb_rd_i),
    .wdata_i  (wb_data_i),
    .re1_i    (rs1_read),
    .raddr1_i (rs1_addr),
    .rdata1_o (rf_rdata1),
    .re2_i    (rs2_read),
    .raddr2_i (rs2_addr),
    .rdata2_o (rf_rdata2)
  );

  id id_i (
    .pc_i                (pc_i),
    .inst_i              (inst_i),
    .rs1_data_i          (rf_rdata1),
    .rs2_data_i          (rf_rdata2),
    .ex_wreg_i           (ex_wreg_i),
    .ex_wreg_data_i      (ex_wreg_data_i),
    .ex_rd_i             (ex_rd_i),
    .ex_memrd_i          (ex_memrd_i),
    .mem_wreg_i          (mem_wreg_i),
    .mem_wreg_data_i     (mem_wreg_data_i),
    .mem_rd_i            (mem_rd_i),
    .mem_memrd_i         (mem_memrd_i),
    .in_delayslot_i      (in_delayslot),
    .rs1_read_o          (rs1_read),
    .rs2_read_o          (rs2_read),
    .rs1_addr_o          (rs1_addr),
    .rs2_addr_o          (rs2_addr),
    .aluop_o             (aluop),
    .alusrc1_o           (alusrc1),
    .alusrc2_o           (alusrc2),
    .imm_o               (imm),
    .rs1_data_o          (rs1_data),
    .rs2_data_o          (rs2_data),
    .rd_o                (rd),
    .wreg_o              (wreg),
    .memrd_o             (memrd),
    .memwr_o             (memwr),
    .mem2reg_o           (mem2reg),
    .func3_o             (func3),
    .link_addr_o         (link_addr),
    .branch_taken_o      (branch_taken_o),
    .branch_target_o     (branch_target_o),
    .next_in_delayslot_o (next_in_delayslot),
    .stallreq_o          (stall_o)
  );

  id_ex id_ex_i (
    .clk                 (clk),
    .rst_n_i             (rst_n_i),
    .stall_i             (stall_o),
    .pc_i                (pc_i),
    .aluop_i             (aluop),
    .alusrc1_i           (alusrc1),
    .alusrc2_i           (alusrc2),
    .imm_i               (imm),
    .rs1_data_i          (rs1_data),
    .rs2_data_i          (rs2_data),
    .rd_i                (rd),
    .wreg_i              (wreg),
    .memrd_i             (memrd),
    .memwr_i             (memwr),
    .mem2reg_i           (mem2reg),
    .func3_i             (func3),
    .link_addr_i         (link_addr),
    .next_in_delayslot_i (next_in_delayslot),
    .iss_pc_o            (iss_pc_o),
    .iss_aluop_o         (iss_aluop_o),
    .iss_alusrc1_o       (iss_alusrc1_o),
    .iss_alusrc2_o       (iss_alusrc2_o),
    .iss_imm_o           (iss_imm_o),
    .iss_rs1_data_o      (iss_rs1_data_o),
    .iss_rs2_data_o      (iss_rs2_data_o),
    .iss_rd_o            (iss_rd_o),
    .iss_wreg_o          (iss_wreg_o),
    .iss_memrd_o         (iss_memrd_o),
    .iss_memwr_o         (iss_memwr_o),
    .iss_mem2reg_o       (iss_mem2reg_o),
    .iss_func3_o         (iss_func3_o),
    .iss_link_addr_o     (iss_link_addr_o),
    .in_delayslot_o      (in_delayslot)
  );

endmodule

//--- verilog/id.sv
`timescale 1ns/1ns

module id
  import rv_pkg::*;
(
  input  word_t     pc_i,
  input  inst_t     inst_i,
  input  word_t     rs1_data_i,
  input  word_t     rs2_data_i,
  input  logic      ex_wreg_i,
  input  word_t     ex_wreg_data_i,
  input  reg_addr_t ex_rd_i,
  input  logic      ex_memrd_i,
  input  logic      mem_wreg_i,
  input  word_t     mem_wreg_data_i,
  input  reg_addr_t mem_rd_i,
  input  logic      mem_memrd_i,
  input  logic      in_delayslot_i,
  output logic      rs1_read_o,
  output logic      rs2_read_o,
  output reg_addr_t rs1_addr_o,
  output reg_addr_t rs2_addr_o,
  output aluop_t    aluop_o,
  output logic      alusrc1_o,
  output logic      alusrc2_o,
  output word_t     imm_o,
  output word_t     rs1_data_o,
  output word_t     rs2_data_o,
  output reg_addr_t rd_o,
  output logic      wreg_o,
  output logic      memrd_o,
  output logic      memwr_o,
  output logic      mem2reg_o,
  output func3_t    func3_o,
  output word_t     link_addr_o,
  output logic      branch_taken_o,
  output word_t     branch_target_o,
  output logic      next_in_delayslot_o,
  output logic      stallreq_o
);

  opcode_t opcode;
  word_t   imm_i_type;
  word_t   imm_s_type;
  word_t   imm_b_type;
  word_t   imm_u_type;
  word_t   imm_j_type;
  logic    is_jal;
  logic    is_jalr;
  logic    is_cond;
  logic    cond_taken;

  // producer hit, x0 never forwarded
  function automatic logic src_hit(input logic rd_en, input reg_addr_t addr,
                                   input logic wreg, input reg_addr_t rd);
    src_hit = rd_en && wreg && (rd != NOP_REG) && (rd == addr);
  endfunction

  function automatic logic load_hit(input logic rd_en, input reg_addr_t addr,
                                    input logic wreg, input logic memrd,
                                    input reg_addr_t rd);
    load_hit = rd_en && wreg && memrd && (rd == addr);
  endfunction

  assign opcode  = inst_i[6:0];
  assign func3_o = inst_i[14:12];

  assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_s_type = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign imm_b_type = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                       inst_i[11:8], 1'b0};
  assign imm_u_type = {inst_i[31:12], 12'b0};
  assign imm_j_type = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                       inst_i[30:21], 1'b0};

  always_comb begin
    aluop_o    = aluop_t'(1) << ALUOP_ADD;
    alusrc1_o  = SRC1_FROM_REG;
    alusrc2_o  = SRC2_FROM_REG;
    imm_o      = ZERO_WORD;
    rd_o       = NOP_REG;
    wreg_o     = 1'b0;
    memrd_o    = 1'b0;
    memwr_o    = 1'b0;
    mem2reg_o  = 1'b0;
    rs1_read_o = 1'b0;
    rs2_read_o = 1'b0;
    rs1_addr_o = NOP_REG;
    rs2_addr_o = NOP_REG;
    is_jal     = 1'b0;
    is_jalr    = 1'b0;
    is_cond    = 1'b0;
    if (!in_delayslot_i) begin // slot after a taken branch stays a nop
      case (opcode)
        OP_LUI: begin
          rd_o      = inst_i[11:7];
          wreg_o    = 1'b1;
          alusrc2_o = SRC2_FROM_IMM;
          imm_o     = imm_u_type;
        end
        OP_AUIPC: begin
          rd_o      = inst_i[11:7];
          wreg_o    = 1'b1;
          alusrc1_o = SRC1_FROM_PC;
          alusrc2_o = SRC2_FROM_IMM;
          imm_o     = imm_u_type;
        end
        OP_JAL: begin
          aluop_o = aluop_t'(1) << ALUOP_LINK;
          rd_o    = inst_i[11:7];
          wreg_o  = 1'b1;
          imm_o   = imm_j_type;
          is_jal  = 1'b1;
        end
        OP_JALR: begin
          aluop_o    = aluop_t'(1) << ALUOP_LINK;
          rd_o       = inst_i[11:7];
          wreg_o     = 1'b1;
          rs1_read_o = 1'b1;
          rs1_addr_o = inst_i[19:15];
          imm_o      = imm_i_type;
          is_jalr    = 1'b1;
        end
        OP_BRANCH: begin
          rs1_read_o = 1'b1;
          rs2_read_o = 1'b1;
          rs1_addr_o = inst_i[19:15];
          rs2_addr_o = inst_i[24:20];
          imm_o      = imm_b_type;
          is_cond    = 1'b1;
        end
        OP_LOAD: begin
          rd_o       = inst_i[11:7];
          wreg_o     = 1'b1;
          alusrc2_o  = SRC2_FROM_IMM;
          rs1_read_o = 1'b1;
          rs1_addr_o = inst_i[19:15];
          imm_o      = imm_i_type;
          memrd_o    = 1'b1;
          mem2reg_o  = 1'b1;
        end
        OP_STORE: begin
          alusrc2_o  = SRC2_FROM_IMM;
          rs1_read_o = 1'b1;
          rs2_read_o = 1'b1;
          rs1_addr_o = inst_i[19:15];
          rs2_addr_o = inst_i[24:20];
          imm_o      = imm_s_type;
          memwr_o    = 1'b1;
        end
        OP_ARITHI, OP_ARITHR: begin
          case (func3_o)
            F3_ADD:  aluop_o = aluop_t'(1) << ((opcode == OP_ARITHR && inst_i[30]) ?
                                               ALUOP_SUB : ALUOP_ADD);
            F3_SLL:  aluop_o = aluop_t'(1) << ALUOP_SLL;
            F3_SLT:  aluop_o = aluop_t'(1) << ALUOP_SLT;
            F3_SLTU: aluop_o = aluop_t'(1) << ALUOP_SLTU;
            F3_XOR:  aluop_o = aluop_t'(1) << ALUOP_XOR;
            F3_SR:   aluop_o = aluop_t'(1) << (inst_i[30] ? ALUOP_SRA : ALUOP_SRL);
            F3_OR:   aluop_o = aluop_t'(1) << ALUOP_OR;
            default: aluop_o = aluop_t'(1) << ALUOP_AND;
          endcase
          rd_o       = inst_i[11:7];
          wreg_o     = 1'b1;
          rs1_read_o = 1'b1;
          rs1_addr_o = inst_i[19:15];
          if (opcode == OP_ARITHI) begin
            alusrc2_o = SRC2_FROM_IMM;
            imm_o     = imm_i_type;
          end else begin
            rs2_read_o = 1'b1;
            rs2_addr_o = inst_i[24:20];
          end
        end
        OP_FENCE, OP_SYSTEM: ; // no effect at this stage
        default: ;
      endcase
    end
  end

  // ex beats mem beats regfile
  assign rs1_data_o = src_hit(rs1_read_o, rs1_addr_o, ex_wreg_i, ex_rd_i)   ? ex_wreg_data_i :
                      src_hit(rs1_read_o, rs1_addr_o, mem_wreg_i, mem_rd_i) ? mem_wreg_data_i :
                      rs1_read_o ? rs1_data_i : ZERO_WORD;
  assign rs2_data_o = src_hit(rs2_read_o, rs2_addr_o, ex_wreg_i, ex_rd_i)   ? ex_wreg_data_i :
                      src_hit(rs2_read_o, rs2_addr_o, mem_wreg_i, mem_rd_i) ? mem_wreg_data_i :
                      rs2_read_o ? rs2_data_i : ZERO_WORD;

  assign stallreq_o =
    load_hit(rs1_read_o, rs1_addr_o, ex_wreg_i, ex_memrd_i, ex_rd_i) ||
    load_hit(rs1_read_o, rs1_addr_o, mem_wreg_i, mem_memrd_i, mem_rd_i) ||
    load_hit(rs2_read_o, rs2_addr_o, ex_wreg_i, ex_memrd_i, ex_rd_i) ||
    load_hit(rs2_read_o, rs2_addr_o, mem_wreg_i, mem_memrd_i, mem_rd_i);

  always_comb begin
    case (func3_o)
      F3_BEQ:  cond_taken = (rs1_data_o == rs2_data_o);
      F3_BNE:  cond_taken = (rs1_data_o != rs2_data_o);
      F3_BLT:  cond_taken = ($signed(rs1_data_o) < $signed(rs2_data_o));
      F3_BGE:  cond_taken = ($signed(rs1_data_o) >= $signed(rs2_data_o));
      F3_BLTU: cond_taken = (rs1_data_o < rs2_data_o);
      F3_BGEU: cond_taken = (rs1_data_o >= rs2_data_o);
      default: cond_taken = 1'b0;
    endcase
  end

  always_comb begin
    branch_taken_o  = 1'b0;
    branch_target_o = ZERO_WORD;
    link_addr_o     = ZERO_WORD;
    if (is_jal) begin
      branch_taken_o  = 1'b1;
      branch_target_o = pc_i + imm_o;
      link_addr_o     = pc_i + 32'd4;
    end else if (is_jalr) begin
      branch_taken_o  = 1'b1;
      branch_target_o = rs1_data_o + imm_o; // forwarded base
      link_addr_o     = pc_i + 32'd4;
    end else if (is_cond) begin
      branch_taken_o  = cond_taken;
      branch_target_o = pc_i + imm_o;
    end
  end

  assign next_in_delayslot_o = branch_taken_o;

  always_comb begin
    aluop_onehot_a: assert ($onehot(aluop_o));
  end

endmodule

//--- verilog/id_ex.sv
`timescale 1ns/1ns

module id_ex
  import rv_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n_i,
  input  logic      stall_i,
  input  word_t     pc_i,
  input  aluop_t    aluop_i,
  input  logic      alusrc1_i,
  input  logic      alusrc2_i,
  input  word_t     imm_i,
  input  word_t     rs1_data_i,
  input  word_t     rs2_data_i,
  input  reg_addr_t rd_i,
  input  logic      wreg_i,
  input  logic      memrd_i,
  input  logic      memwr_i,
  input  logic      mem2reg_i,
  input  func3_t    func3_i,
  input  word_t     link_addr_i,
  input  logic      next_in_delayslot_i,
  output word_t     iss_pc_o,
  output aluop_t    iss_aluop_o,
  output logic      iss_alusrc1_o,
  output logic      iss_alusrc2_o,
  output word_t     iss_imm_o,
  output word_t     iss_rs1_data_o,
  output word_t     iss_rs2_data_o,
  output reg_addr_t iss_rd_o,
  output logic      iss_wreg_o,
  output logic      iss_memrd_o,
  output logic      iss_memwr_o,
  output logic      iss_mem2reg_o,
  output func3_t    iss_func3_o,
  output word_t     iss_link_addr_o,
  output logic      in_delayslot_o
);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      iss_aluop_o    <= aluop_t'(1) << ALUOP_ADD;
      iss_rd_o       <= NOP_REG;
      iss_wreg_o     <= 1'b0;
      iss_memrd_o    <= 1'b0;
      iss_memwr_o    <= 1'b0;
      iss_mem2reg_o  <= 1'b0;
      in_delayslot_o <= 1'b0;
    end else if (stall_i) begin
      // bubble, delay-slot flag keeps its value
      iss_aluop_o   <= aluop_t'(1) << ALUOP_ADD;
      iss_rd_o      <= NOP_REG;
      iss_wreg_o    <= 1'b0;
      iss_memrd_o   <= 1'b0;
      iss_memwr_o   <= 1'b0;
      iss_mem2reg_o <= 1'b0;
    end else begin
      iss_aluop_o    <= aluop_i;
      iss_rd_o       <= rd_i;
      iss_wreg_o     <= wreg_i;
      iss_memrd_o    <= memrd_i;
      iss_memwr_o    <= memwr_i;
      iss_mem2reg_o  <= mem2reg_i;
      in_delayslot_o <= next_in_delayslot_i;
    end
  end

  always_ff @(posedge clk) begin
    iss_pc_o        <= pc_i;
    iss_alusrc1_o   <= alusrc1_i;
    iss_alusrc2_o   <= alusrc2_i;
    iss_imm_o       <= imm_i;
    iss_rs1_data_o  <= rs1_data_i;
    iss_rs2_data_o  <= rs2_data_i;
    iss_func3_o     <= func3_i;
    iss_link_addr_o <= link_addr_i;
  end

  stall_bubble_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    stall_i |=> (!iss_wreg_o && !iss_memrd_o && !iss_memwr_o));

endmodule

//--- verilog/regfile.sv
`timescale 1ns/1ns

module regfile
  import rv_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n_i,
  input  logic      we_i,
  input  reg_addr_t waddr_i,
  input  word_t     wdata_i,
  input  logic      re1_i,
  input  reg_addr_t raddr1_i,
  output word_t     rdata1_o,
  input  logic      re2_i,
  input  reg_addr_t raddr2_i,
  output word_t     rdata2_o
);

  word_t regs [REG_NUM];

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < REG_NUM; i++) begin
        regs[i] <= ZERO_WORD;
      end
    end else if (we_i && (waddr_i != NOP_REG)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // same-cycle write passes straight to the reader
  always_comb begin
    if (!re1_i || (raddr1_i == NOP_REG)) begin
      rdata1_o = ZERO_WORD;
    end else if (we_i && (waddr_i == raddr1_i)) begin
      rdata1_o = wdata_i;
    end else begin
      rdata1_o = regs[raddr1_i];
    end
  end

  always_comb begin
    if (!re2_i || (raddr2_i == NOP_REG)) begin
      rdata2_o = ZERO_WORD;
    end else if (we_i && (waddr_i == raddr2_i)) begin
      rdata2_o = wdata_i;
    end else begin
      rdata2_o = regs[raddr2_i];
    end
  end

  x0_zero_a: assert property (@(posedge clk) disable iff (!rst_n_i) regs[0] == ZERO_WORD);

endmodule

//--- verilog/rv_pkg.sv
package rv_pkg;

  localparam int ALUOP_NUM = 11;
  localparam int REG_NUM   = 32;

  typedef logic [31:0]          word_t;
  typedef logic [31:0]          inst_t;
  typedef logic [4:0]           reg_addr_t;
  typedef logic [2:0]           func3_t;
  typedef logic [6:0]           opcode_t;
  typedef logic [ALUOP_NUM-1:0] aluop_t; // one-hot

  // bit positions inside aluop_t
  localparam int ALUOP_ADD  = 0;
  localparam int ALUOP_SUB  = 1;
  localparam int ALUOP_SLL  = 2;
  localparam int ALUOP_SLT  = 3;
  localparam int ALUOP_SLTU = 4;
  localparam int ALUOP_XOR  = 5;
  localparam int ALUOP_SRL  = 6;
  localparam int ALUOP_SRA  = 7;
  localparam int ALUOP_OR   = 8;
  localparam int ALUOP_AND  = 9;
  localparam int ALUOP_LINK = 10; // rd gets link address

  localparam opcode_t OP_LUI    = 7'b0110111;
  localparam opcode_t OP_AUIPC  = 7'b0010111;
  localparam opcode_t OP_JAL    = 7'b1101111;
  localparam opcode_t OP_JALR   = 7'b1100111;
  localparam opcode_t OP_BRANCH = 7'b1100011;
  localparam opcode_t OP_LOAD   = 7'b0000011;
  localparam opcode_t OP_STORE  = 7'b0100011;
  localparam opcode_t OP_ARITHI = 7'b0010011;
  localparam opcode_t OP_ARITHR = 7'b0110011;
  localparam opcode_t OP_FENCE  = 7'b0001111;
  localparam opcode_t OP_SYSTEM = 7'b1110011;

  // branch conditions
  localparam func3_t F3_BEQ  = 3'b000;
  localparam func3_t F3_BNE  = 3'b001;
  localparam func3_t F3_BLT  = 3'b100;
  localparam func3_t F3_BGE  = 3'b101;
  localparam func3_t F3_BLTU = 3'b110;
  localparam func3_t F3_BGEU = 3'b111;

  // alu group, shared by immediate and register forms
  localparam func3_t F3_ADD  = 3'b000;
  localparam func3_t F3_SLL  = 3'b001;
  localparam func3_t F3_SLT  = 3'b010;
  localparam func3_t F3_SLTU = 3'b011;
  localparam func3_t F3_XOR  = 3'b100;
  localparam func3_t F3_SR   = 3'b101; // srl or sra by inst[30]
  localparam func3_t F3_OR   = 3'b110;
  localparam func3_t F3_AND  = 3'b111;

  localparam logic SRC1_FROM_REG = 1'b0;
  localparam logic SRC1_FROM_PC  = 1'b1;
  localparam logic SRC2_FROM_REG = 1'b0;
  localparam logic SRC2_FROM_IMM = 1'b1;

  localparam word_t     ZERO_WORD = 32'h0000_0000;
  localparam reg_addr_t NOP_REG   = 5'd0;

endpackage
